/* mips_cfg.svh */
/*
 * MIPS core configuration
 * data width, register count, data memory depth and reset PC
 */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and address width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_RF_REGS 32

// data memory depth in words
`define MIPS_DMEM_WORDS 128

// fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* mipsIsaPkg.sv */
/*
 * MIPS instruction-set package
 * opcode and funct encodings, instruction field widths, register index type
 */
`default_nettype none

package mipsIsaPkg;

  // ====================================================================
  // instruction field widths
  // ====================================================================
  localparam int OPCODE_W   = 6;
  localparam int FUNCT_W    = 6;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int JIDX_W     = 26;

  // primary opcodes of the supported subset
  typedef enum logic [OPCODE_W-1:0] {
    OP_RTYPE = 6'd0,
    OP_J     = 6'd2,
    OP_JAL   = 6'd3,
    OP_BEQ   = 6'd4,
    OP_ADDI  = 6'd8,
    OP_LW    = 6'd35,
    OP_SW    = 6'd43
  } opcode_t;

  // R-type function field
  typedef enum logic [FUNCT_W-1:0] {
    FN_ADD = 6'd32,
    FN_SUB = 6'd34,
    FN_AND = 6'd36,
    FN_OR  = 6'd37,
    FN_SLT = 6'd42
  } funct_t;

  typedef logic [REG_ADDR_W-1:0] regAddr_t;

  // jal return address lands here
  localparam regAddr_t LINK_REG = 5'd31;

endpackage

`default_nettype wire

/* mipsCtrlPkg.sv */
/*
 * MIPS control package
 * ALU operation class from the main decoder and ALU function codes
 */
`default_nettype none

package mipsCtrlPkg;

  // operation class passed from main decoder to ALU decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'd0,
    ALUOP_SUB   = 2'd1,
    ALUOP_FUNCT = 2'd2
  } aluOp_t;

  // ALU function select
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_OR   = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0110,
    ALU_SLT  = 4'b0111,
    ALU_PASS = 4'b1111
  } aluCtrl_t;

endpackage

`default_nettype wire

/* mainDecoder.sv */
/*
 * Main decoder
 * opcode to datapath control levels and ALU operation class
 */
`timescale 1ns/1ps
`default_nettype none

module mainDecoder
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;
(
  input  opcode_t opcode,
  output logic    regDst,
  output logic    aluSrc,
  output logic    memToReg,
  output logic    regWrite,
  output logic    memWrite,
  output logic    branch,
  output logic    jump,
  output logic    link,
  output aluOp_t  aluOp
);

  always_comb begin
    // unknown opcodes fall through as a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = ALUOP_ADD;
    case (opcode)
      OP_RTYPE: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluOp    = ALUOP_FUNCT;
      end
      OP_ADDI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      OP_LW: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      OP_BEQ: begin
        branch = 1'b1;
        aluOp  = ALUOP_SUB;
      end
      OP_J:    jump = 1'b1;
      OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* aluDecoder.sv */
/*
 * ALU decoder
 * operation class plus funct field to ALU function code
 */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;
(
  input  aluOp_t   aluOp,
  input  funct_t   funct,
  output aluCtrl_t aluCtrl
);

  always_comb begin
    case (aluOp)
      ALUOP_ADD: aluCtrl = ALU_ADD;
      ALUOP_SUB: aluCtrl = ALU_SUB;
      ALUOP_FUNCT: begin
        case (funct)
          FN_ADD:  aluCtrl = ALU_ADD;
          FN_SUB:  aluCtrl = ALU_SUB;
          FN_AND:  aluCtrl = ALU_AND;
          FN_OR:   aluCtrl = ALU_OR;
          FN_SLT:  aluCtrl = ALU_SLT;
          // core drops the write for an unsupported funct
          default: aluCtrl = ALU_PASS;
        endcase
      end
      default: aluCtrl = ALU_PASS;
    endcase
  end

endmodule

`default_nettype wire

/* alu.sv */
/*
 * ALU
 * and, or, add, sub and signed set-less-than with a zero flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module alu
  import mipsCtrlPkg::*;
(
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  aluCtrl_t              aluCtrl,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  logic lessThan;

  // signed compare for slt
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluCtrl)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
      default: result = a;
    endcase
  end

  // beq relies on this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* regFile.sv */
/*
 * Register file
 * two combinational read ports, one write port at the clock edge,
 * register 0 hard-wired to zero
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module regFile
  import mipsIsaPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  writeEn,
  input  regAddr_t              readAddrA,
  input  regAddr_t              readAddrB,
  input  regAddr_t              writeAddr,
  input  logic [`MIPS_XLEN-1:0] writeData,
  output logic [`MIPS_XLEN-1:0] readDataA,
  output logic [`MIPS_XLEN-1:0] readDataB
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_RF_REGS];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MIPS_RF_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // r0 always reads zero
  assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* pcUnit.sv */
/*
 * Program counter
 * picks jump, taken branch or PC+4 and loads it at the clock edge
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module pcUnit
  import mipsIsaPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branchTaken,
  input  logic                  jump,
  input  logic [`MIPS_XLEN-1:0] branchOffset,
  input  logic [JIDX_W-1:0]     jumpIndex,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] pcPlus4
);

  logic [`MIPS_XLEN-1:0] branchTarget;
  logic [`MIPS_XLEN-1:0] jumpTarget;
  logic [`MIPS_XLEN-1:0] pcNext;

  assign pcPlus4 = pc + `MIPS_XLEN'd4;

  // word offset scaled to bytes
  assign branchTarget = pcPlus4 + {branchOffset[`MIPS_XLEN-3:0], 2'b00};

  // region bits come from PC+4
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], jumpIndex, 2'b00};

  // jump wins over branch, branch over fall-through
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

/* dataMem.sv */
/*
 * Data memory
 * word array, combinational read and write at the clock edge
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module dataMem #(
  parameter int DEPTH = `MIPS_DMEM_WORDS
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     writeEn,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [`MIPS_XLEN-1:0]    writeData,
  output logic [`MIPS_XLEN-1:0]    readData
);

  logic [`MIPS_XLEN-1:0] mem [DEPTH];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (writeEn) begin
      mem[addr] <= writeData;
    end
  end

  // lw sees the word in the same cycle
  assign readData = mem[addr];

endmodule

`default_nettype wire

/* mipsCore.sv */
/*
 * Single-cycle MIPS core
 * field split, immediate extension, operand and write-back muxes,
 * decoders, ALU, register file and PC
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mipsCore
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;
#(
  parameter int MEM_ADDR_W = $clog2(`MIPS_DMEM_WORDS)
) (
  input  logic                  clk,
  input  logic                  rst,
  output logic [`MIPS_XLEN-1:0] irAddr,
  input  logic [`MIPS_XLEN-1:0] ir,
  output logic                  memWriteEn,
  output logic [MEM_ADDR_W-1:0] memAddr,
  output logic [`MIPS_XLEN-1:0] memWriteData,
  input  logic [`MIPS_XLEN-1:0] memReadData,
  output logic                  rfWriteEn,
  output regAddr_t              rfWriteAddr,
  output logic [`MIPS_XLEN-1:0] rfWriteData
);

  // ====================================================================
  // instruction fields
  // ====================================================================
  opcode_t           opcode;
  funct_t            funct;
  regAddr_t          rs;
  regAddr_t          rt;
  regAddr_t          rd;
  logic [IMM_W-1:0]  imm;
  logic [JIDX_W-1:0] jumpIndex;

  assign opcode    = opcode_t'(ir[31:26]);
  assign rs        = ir[25:21];
  assign rt        = ir[20:16];
  assign rd        = ir[15:11];
  assign imm       = ir[IMM_W-1:0];
  assign funct     = funct_t'(ir[FUNCT_W-1:0]);
  assign jumpIndex = ir[JIDX_W-1:0];

  logic regDst, aluSrc, memToReg, regWrite, memWrite, branch, jump, link;
  aluOp_t   aluOp;
  aluCtrl_t aluCtrl;

  logic [`MIPS_XLEN-1:0] immExt;
  logic [`MIPS_XLEN-1:0] readDataA;
  logic [`MIPS_XLEN-1:0] readDataB;
  logic [`MIPS_XLEN-1:0] aluB;
  logic [`MIPS_XLEN-1:0] aluResult;
  logic                  aluZero;
  logic [`MIPS_XLEN-1:0] pcPlus4;

  mainDecoder uMainDec (
    .opcode   (opcode),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluOp)
  );

  aluDecoder uAluDec (
    .aluOp   (aluOp),
    .funct   (funct),
    .aluCtrl (aluCtrl)
  );

  // ====================================================================
  // execute
  // ====================================================================
  assign immExt = {{(`MIPS_XLEN-IMM_W){imm[IMM_W-1]}}, imm};
  assign aluB   = aluSrc ? immExt : readDataB;

  alu uAlu (
    .a       (readDataA),
    .b       (aluB),
    .aluCtrl (aluCtrl),
    .result  (aluResult),
    .zero    (aluZero)
  );

  // unknown funct behaves as a no-op
  assign rfWriteEn = regWrite && (aluCtrl != ALU_PASS);

  // destination is the link register, rd or rt
  assign rfWriteAddr = link ? LINK_REG : (regDst ? rd : rt);

  // jal returns to the next instruction as there is no delay slot
  assign rfWriteData = link ? pcPlus4 : (memToReg ? memReadData : aluResult);

  regFile uRegFile (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (rfWriteEn),
    .readAddrA (rs),
    .readAddrB (rt),
    .writeAddr (rfWriteAddr),
    .writeData (rfWriteData),
    .readDataA (readDataA),
    .readDataB (readDataB)
  );

  pcUnit uPc (
    .clk          (clk),
    .rst          (rst),
    .branchTaken  (branch && aluZero),
    .jump         (jump),
    .branchOffset (immExt),
    .jumpIndex    (jumpIndex),
    .pc           (irAddr),
    .pcPlus4      (pcPlus4)
  );

  // byte address to word index
  assign memWriteEn   = memWrite;
  assign memAddr      = aluResult[MEM_ADDR_W+1:2];
  assign memWriteData = readDataB;

endmodule

`default_nettype wire

/* mipsSystem.sv */
/*
 * MIPS system top
 * joins the core with its data memory while instruction fetch stays outside
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mipsSystem
  import mipsIsaPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MIPS_XLEN-1:0] ir,
  output logic [`MIPS_XLEN-1:0] irAddr,
  output logic                  rfWriteEn,
  output regAddr_t              rfWriteAddr,
  output logic [`MIPS_XLEN-1:0] rfWriteData
);

  localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

  logic                  memWriteEn;
  logic [DMEM_AW-1:0]    memAddr;
  logic [`MIPS_XLEN-1:0] memWriteData;
  logic [`MIPS_XLEN-1:0] memReadData;

  mipsCore #(.MEM_ADDR_W(DMEM_AW)) uCore (
    .clk          (clk),
    .rst          (rst),
    .irAddr       (irAddr),
    .ir           (ir),
    .memWriteEn   (memWriteEn),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memReadData  (memReadData),
    .rfWriteEn    (rfWriteEn),
    .rfWriteAddr  (rfWriteAddr),
    .rfWriteData  (rfWriteData)
  );

  dataMem #(.DEPTH(`MIPS_DMEM_WORDS)) uDataMem (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (memWriteEn),
    .addr      (memAddr),
    .writeData (memWriteData),
    .readData  (memReadData)
  );

endmodule

`default_nettype wire

/* tbMips.sv */
/*
 * MIPS system testbench
 * builds a directed plus random program, feeds it as instruction memory
 * and checks PC and register writes against an instruction-set model
 */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module tbMips
  import mipsIsaPkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int PROG_LEN    = 200;
  localparam int LOOP_IDX    = PROG_LEN - 1;
  localparam int LOOP_HOLD   = 20;
  localparam int CYCLE_LIMIT = PROG_LEN * 2 + 50;
  localparam int DMEM_WORDS  = `MIPS_DMEM_WORDS;
  localparam int DMEM_AW     = $clog2(`MIPS_DMEM_WORDS);
  localparam logic [`MIPS_XLEN-1:0] LOOP_PC = LOOP_IDX * 4;
  localparam logic [31:0] RAND_SEED = 32'h19f51d31;

  logic                  clk;
  logic                  rst;
  logic [`MIPS_XLEN-1:0] ir;
  logic [`MIPS_XLEN-1:0] irAddr;
  logic                  rfWriteEn;
  regAddr_t              rfWriteAddr;
  logic [`MIPS_XLEN-1:0] rfWriteData;

  logic [31:0]           prog [PROG_LEN];
  int                    progCount;
  logic [`MIPS_XLEN-1:0] modelRegs [`MIPS_RF_REGS];
  logic [`MIPS_XLEN-1:0] modelMem [DMEM_WORDS];
  logic [`MIPS_XLEN-1:0] modelPc;
  int                    loopCycles;
  int                    cycleCount;

  mipsSystem u_dut (
    .clk         (clk),
    .rst         (rst),
    .ir          (ir),
    .irAddr      (irAddr),
    .rfWriteEn   (rfWriteEn),
    .rfWriteAddr (rfWriteAddr),
    .rfWriteData (rfWriteData)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================================================================
  // instruction encoding and program build
  // ====================================================================
  function automatic logic [31:0] rTypeInstr(input funct_t fn, input regAddr_t rd,
                                             input regAddr_t rs, input regAddr_t rt);
    rTypeInstr = {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  // arguments follow assembly order with rt before rs and imm last
  function automatic logic [31:0] immInstr(input opcode_t op, input regAddr_t rt,
                                           input regAddr_t rs, input logic [15:0] imm);
    immInstr = {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jumpInstr(input opcode_t op, input int target);
    jumpInstr = {op, 26'(target)};
  endfunction

  function automatic regAddr_t randReg();
    randReg = regAddr_t'($urandom_range(31, 0));
  endfunction

  function automatic funct_t randFunct();
    case ($urandom_range(4, 0))
      0:       randFunct = FN_ADD;
      1:       randFunct = FN_SUB;
      2:       randFunct = FN_AND;
      3:       randFunct = FN_OR;
      default: randFunct = FN_SLT;
    endcase
  endfunction

  // byte offset of a word inside data memory
  function automatic logic [15:0] randWordOffset();
    randWordOffset = 16'(4 * $urandom_range(DMEM_WORDS - 1, 0));
  endfunction

  task automatic appendInstr(input logic [31:0] word);
    prog[8'(progCount)] = word;
    progCount++;
  endtask

  task automatic buildProgram();
    int kind;
    int off;
    progCount = 0;
    // arithmetic from cleared registers
    appendInstr(immInstr(OP_ADDI, 5'd1, 5'd0, 16'd5));
    appendInstr(immInstr(OP_ADDI, 5'd2, 5'd0, 16'hfffd));
    appendInstr(rTypeInstr(FN_ADD, 5'd3, 5'd1, 5'd2));
    appendInstr(rTypeInstr(FN_SUB, 5'd4, 5'd1, 5'd2));
    appendInstr(rTypeInstr(FN_AND, 5'd5, 5'd1, 5'd2));
    appendInstr(rTypeInstr(FN_OR, 5'd6, 5'd1, 5'd2));
    appendInstr(rTypeInstr(FN_SLT, 5'd7, 5'd2, 5'd1));
    appendInstr(rTypeInstr(FN_SLT, 5'd8, 5'd1, 5'd2));
    appendInstr(immInstr(OP_ADDI, 5'd9, 5'd1, 16'h7fff));
    // store and load round trips
    appendInstr(immInstr(OP_ADDI, 5'd10, 5'd0, 16'd64));
    appendInstr(immInstr(OP_SW, 5'd3, 5'd10, 16'd0));
    appendInstr(immInstr(OP_SW, 5'd4, 5'd10, 16'd4));
    appendInstr(immInstr(OP_LW, 5'd11, 5'd10, 16'd0));
    appendInstr(immInstr(OP_LW, 5'd12, 5'd10, 16'd4));
    appendInstr(immInstr(OP_LW, 5'd13, 5'd10, 16'd8));
    appendInstr(immInstr(OP_SW, 5'd9, 5'd0, 16'd12));
    appendInstr(immInstr(OP_LW, 5'd14, 5'd0, 16'd12));
    // beq taken skips one and then beq not taken
    appendInstr(immInstr(OP_BEQ, 5'd1, 5'd1, 16'd1));
    appendInstr(immInstr(OP_ADDI, 5'd15, 5'd0, 16'd1));
    appendInstr(immInstr(OP_BEQ, 5'd1, 5'd2, 16'd1));
    appendInstr(immInstr(OP_ADDI, 5'd16, 5'd0, 16'd2));
    // j and jal over one instruction each
    appendInstr(jumpInstr(OP_J, progCount + 2));
    appendInstr(immInstr(OP_ADDI, 5'd15, 5'd0, 16'd3));
    appendInstr(jumpInstr(OP_JAL, progCount + 2));
    appendInstr(immInstr(OP_ADDI, 5'd15, 5'd0, 16'd4));
    appendInstr(rTypeInstr(FN_ADD, 5'd17, 5'd31, 5'd0));
    // r0 stays zero
    appendInstr(immInstr(OP_ADDI, 5'd0, 5'd0, 16'd77));
    appendInstr(rTypeInstr(FN_ADD, 5'd18, 5'd0, 5'd0));
    appendInstr(rTypeInstr(FN_OR, 5'd19, 5'd0, 5'd1));
    // random body with forward-only flow changes so the run always ends
    while (progCount < LOOP_IDX) begin
      kind = int'($urandom_range(9, 0));
      off  = int'($urandom_range(LOOP_IDX - progCount - 1, 0));
      case (kind)
        0, 1, 2: appendInstr(rTypeInstr(randFunct(), randReg(), randReg(), randReg()));
        3, 4:    appendInstr(immInstr(OP_ADDI, randReg(), randReg(),
                                      16'($urandom_range(65535, 0))));
        5:       appendInstr(immInstr(OP_SW, randReg(), 5'd0, randWordOffset()));
        6:       appendInstr(immInstr(OP_LW, randReg(), 5'd0, randWordOffset()));
        7:       appendInstr(immInstr(OP_BEQ, randReg(), randReg(), 16'(off)));
        8:       appendInstr(jumpInstr(OP_J, progCount + 1 + off));
        default: appendInstr(jumpInstr(OP_JAL, progCount + 1 + off));
      endcase
    end
    appendInstr(jumpInstr(OP_J, LOOP_IDX));
  endtask

  // instruction memory lookup returning zero outside the program
  function automatic logic [31:0] fetchWord(input logic [`MIPS_XLEN-1:0] addr);
    if ((addr >> 2) < PROG_LEN) begin
      fetchWord = prog[addr[9:2]];
    end else begin
      fetchWord = '0;
    end
  endfunction

  // ====================================================================
  // reference model
  // ====================================================================
  function automatic void stepModel(
    input  logic [31:0]           instr,
    output logic [`MIPS_XLEN-1:0] nextPc,
    output logic                  wEn,
    output regAddr_t              wAddr,
    output logic [`MIPS_XLEN-1:0] wData
  );
    opcode_t               op;
    funct_t                fn;
    logic [`MIPS_XLEN-1:0] a;
    logic [`MIPS_XLEN-1:0] b;
    logic [`MIPS_XLEN-1:0] immExt;
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] seqPc;
    logic [DMEM_AW-1:0]    memIdx;
    op     = opcode_t'(instr[31:26]);
    fn     = funct_t'(instr[5:0]);
    a      = modelRegs[instr[25:21]];
    b      = modelRegs[instr[20:16]];
    immExt = {{16{instr[15]}}, instr[15:0]};
    addr   = a + immExt;
    memIdx = addr[DMEM_AW+1:2];
    seqPc  = modelPc + 32'd4;
    nextPc = seqPc;
    wEn    = 1'b0;
    wAddr  = instr[20:16];
    wData  = addr;
    case (op)
      OP_RTYPE: begin
        wEn   = 1'b1;
        wAddr = instr[15:11];
        case (fn)
          FN_ADD:  wData = a + b;
          FN_SUB:  wData = a - b;
          FN_AND:  wData = a & b;
          FN_OR:   wData = a | b;
          FN_SLT:  wData = {31'd0, $signed(a) < $signed(b)};
          default: wEn = 1'b0;
        endcase
      end
      OP_ADDI: wEn = 1'b1;
      OP_LW: begin
        wEn   = 1'b1;
        wData = modelMem[memIdx];
      end
      OP_SW:   modelMem[memIdx] = b;
      OP_BEQ: begin
        if (a == b) begin
          nextPc = seqPc + {immExt[29:0], 2'b00};
        end
      end
      OP_J:    nextPc = {seqPc[31:28], instr[25:0], 2'b00};
      OP_JAL: begin
        nextPc = {seqPc[31:28], instr[25:0], 2'b00};
        wEn    = 1'b1;
        wAddr  = LINK_REG;
        wData  = seqPc;
      end
      default: ;
    endcase
    if (wEn && (wAddr != '0)) begin
      modelRegs[wAddr] = wData;
    end
  endfunction

  // ====================================================================
  // checks
  // ====================================================================
  task automatic abortRun();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkPc(input logic [`MIPS_XLEN-1:0] actual,
                         input logic [`MIPS_XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: irAddr is %h, expected %h", $time, actual, expected);
      abortRun();
    end
  endtask

  task automatic checkWrite(input logic actEn, input regAddr_t actAddr,
                            input logic [`MIPS_XLEN-1:0] actData,
                            input logic expEn, input regAddr_t expAddr,
                            input logic [`MIPS_XLEN-1:0] expData);
    if (actEn !== expEn) begin
      $display("MISMATCH at %0t: pc %h rfWriteEn is %b, expected %b",
               $time, modelPc, actEn, expEn);
      abortRun();
    end else if (expEn && ((actAddr !== expAddr) || (actData !== expData))) begin
      $display("MISMATCH at %0t: pc %h write r%0d = %h, expected r%0d = %h",
               $time, modelPc, actAddr, actData, expAddr, expData);
      abortRun();
    end
  endtask

  task automatic compareCycle();
    logic [`MIPS_XLEN-1:0] expNextPc;
    logic                  expEn;
    regAddr_t              expAddr;
    logic [`MIPS_XLEN-1:0] expData;
    checkPc(irAddr, modelPc);
    stepModel(fetchWord(modelPc), expNextPc, expEn, expAddr, expData);
    checkWrite(rfWriteEn, rfWriteAddr, rfWriteData, expEn, expAddr, expData);
    if (modelPc == LOOP_PC) begin
      loopCycles++;
    end
    modelPc = expNextPc;
    if (loopCycles == LOOP_HOLD) begin
      $display("sim passed");
      $finish;
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    clk        = 1'b0;
    rst        = 1'b0;
    modelRegs  = '{default: '0};
    modelMem   = '{default: '0};
    modelPc    = `MIPS_RESET_PC;
    loopCycles = 0;
    cycleCount = 0;
    buildProgram();
    ir = fetchWord(`MIPS_RESET_PC);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;
  end

  // combinational instruction memory driven just after the edge
  always @(posedge clk) begin
    #1;
    ir = fetchWord(irAddr);
  end

  // sample one ns before the next edge
  always @(posedge clk) begin
    #(CLK_PERIOD - 1);
    if (rst) begin
      compareCycle();
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("timeout: the program did not settle in its final loop after %0d cycles",
               cycleCount);
      abortRun();
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mipsIsaPkg.sv
mipsCtrlPkg.sv
mainDecoder.sv
aluDecoder.sv
alu.sv
regFile.sv
pcUnit.sv
dataMem.sv
mipsCore.sv
mipsSystem.sv
tbMips.sv

/* run.sh */
#!/usr/bin/env bash
# build the MIPS testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tbMips -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/VtbMips 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
